// ==== design/refresh_pkg.sv ====
package refresh_pkg;

  // ####################
  // data path widths
  // ####################
  typedef logic [31:0] word_t;   // one axi data word
  typedef logic [31:0] addr_t;   // axi byte address
  typedef logic [2:0]  bank_t;   // bank index, top code(s) map to status
  typedef logic [3:0]  row_t;    // row within a bank
  typedef logic [1:0]  defer_t;  // deferred refresh count
  typedef logic [9:0]  age_t;    // cycles since a bank was last refreshed

  // byte address layout: bank in 8:6, row in 5:2, byte lane in 1:0
  localparam int ROW_LSB  = 2;
  localparam int BANK_LSB = 6;

  // ####################
  // axi response codes
  // ####################
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ####################
  // controller fsm
  // ####################
  typedef enum logic [1:0] {
    ST_IDLE,   // ready for a new address
    ST_WRESP,  // write response held until bready
    ST_RDATA   // read data held until rready
  } ctrl_state_t;

endpackage

// ==== design/mem_access_if.sv ====
// one bank access per cycle, issued by the bus controller
interface mem_access_if;

  logic               acc;    // access this cycle
  logic               we;     // 1 = write, 0 = read
  refresh_pkg::bank_t bank;
  refresh_pkg::row_t  row;
  refresh_pkg::word_t wdata;
  refresh_pkg::word_t rdata;  // registered, valid the cycle after a read

  modport ctrl (
    output acc,
    output we,
    output bank,
    output row,
    output wdata,
    input  rdata
  );

  // scheduler only needs to know which bank is busy
  modport sched (
    input acc,
    input bank
  );

  modport array (
    input  acc,
    input  we,
    input  bank,
    input  row,
    input  wdata,
    output rdata
  );

endinterface

// ==== design/axil_ctrl_fsm.sv ====
module axil_ctrl_fsm #(
  parameter int NUM_BANKS = 7
) (
  input  logic                clk,
  input  logic                rst,
  input  refresh_pkg::addr_t  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  refresh_pkg::word_t  wdata,
  input  logic                wvalid,
  output logic                wready,
  output refresh_pkg::resp_t  bresp,
  output logic                bvalid,
  input  logic                bready,
  input  refresh_pkg::addr_t  araddr,
  input  logic                arvalid,
  output logic                arready,
  output refresh_pkg::word_t  rdata,
  output refresh_pkg::resp_t  rresp,
  output logic                rvalid,
  input  logic                rready,
  input  logic                fault,
  mem_access_if.ctrl          mem
);

  refresh_pkg::ctrl_state_t state, state_nxt;
  logic                     idle_rdy;     // low in reset, high while idle
  logic                     wr_hs, rd_hs;
  refresh_pkg::bank_t       aw_bank, ar_bank;
  refresh_pkg::row_t        aw_row, ar_row;
  logic                     aw_in_range, ar_in_range;
  logic                     rd_status;    // pending read targets the status word
  refresh_pkg::resp_t       wresp_q;

  // ####################
  // address decode
  // ####################
  assign aw_bank = awaddr[refresh_pkg::BANK_LSB +: $bits(refresh_pkg::bank_t)];
  assign aw_row  = awaddr[refresh_pkg::ROW_LSB +: $bits(refresh_pkg::row_t)];
  assign ar_bank = araddr[refresh_pkg::BANK_LSB +: $bits(refresh_pkg::bank_t)];
  assign ar_row  = araddr[refresh_pkg::ROW_LSB +: $bits(refresh_pkg::row_t)];

  assign aw_in_range = (aw_bank < NUM_BANKS);
  assign ar_in_range = (ar_bank < NUM_BANKS);

  // ####################
  // handshakes
  // ####################
  assign awready = idle_rdy;
  assign wready  = idle_rdy;
  assign arready = idle_rdy && !awvalid && !wvalid;  // writes win a tie

  assign wr_hs = idle_rdy && awvalid && wvalid;
  assign rd_hs = arready && arvalid;

  // access goes out in the handshake cycle, status hits never reach the array
  assign mem.acc   = (wr_hs && aw_in_range) || (rd_hs && ar_in_range);
  assign mem.we    = wr_hs;
  assign mem.bank  = wr_hs ? aw_bank : ar_bank;
  assign mem.row   = wr_hs ? aw_row : ar_row;
  assign mem.wdata = wdata;

  always_comb begin
    state_nxt = state;
    case (state)
      refresh_pkg::ST_IDLE: begin
        if (wr_hs)
          state_nxt = refresh_pkg::ST_WRESP;
        else if (rd_hs)
          state_nxt = refresh_pkg::ST_RDATA;
      end
      refresh_pkg::ST_WRESP: if (bready) state_nxt = refresh_pkg::ST_IDLE;
      refresh_pkg::ST_RDATA: if (rready) state_nxt = refresh_pkg::ST_IDLE;
      default: state_nxt = refresh_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= refresh_pkg::ST_IDLE;
      idle_rdy <= 1'b0;
    end else begin
      state    <= state_nxt;
      idle_rdy <= (state_nxt == refresh_pkg::ST_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs)
      wresp_q <= aw_in_range ? refresh_pkg::RESP_OKAY : refresh_pkg::RESP_SLVERR;
    if (rd_hs)
      rd_status <= !ar_in_range;
  end

  // ####################
  // responses
  // ####################
  assign bvalid = (state == refresh_pkg::ST_WRESP);
  assign bresp  = wresp_q;
  assign rvalid = (state == refresh_pkg::ST_RDATA);
  assign rresp  = refresh_pkg::RESP_OKAY;  // every read is legal
  assign rdata  = rd_status ? {31'b0, fault} : mem.rdata;

  // no address is taken while a response is still held
  a_no_hs_busy : assert property (@(posedge clk) disable iff (rst)
    (wr_hs || rd_hs) |-> !(bvalid || rvalid));

endmodule

// ==== design/refresh_timer.sv ====
module refresh_timer #(
  parameter int NUM_BANKS      = 7,
  parameter int REFRESH_PERIOD = 64
) (
  input  logic clk,
  input  logic rst,
  input  logic refr,        // one refresh issued this cycle
  output logic ref_start,   // first cycle of a burst
  output logic ref_window   // burst still owes refreshes
);

  localparam int PW = $clog2(REFRESH_PERIOD);
  localparam int WW = $clog2(NUM_BANKS);

  logic [PW-1:0] period_cnt;
  logic [WW-1:0] win_cnt;

  // free running, wraps every REFRESH_PERIOD cycles
  assign ref_start = (period_cnt == PW'(REFRESH_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (rst)
      period_cnt <= '0;
    else if (ref_start)
      period_cnt <= '0;
    else
      period_cnt <= period_cnt + 1'b1;
  end

  // start cycle takes one refresh, the window covers the rest
  always_ff @(posedge clk) begin
    if (rst)
      win_cnt <= '0;
    else if (ref_start)
      win_cnt <= WW'(NUM_BANKS - 1);
    else if (refr && (win_cnt != '0))
      win_cnt <= win_cnt - 1'b1;
  end

  assign ref_window = (win_cnt != '0);

endmodule

// ==== design/refresh_scheduler.sv ====
module refresh_scheduler #(
  parameter int NUM_BANKS = 7,
  parameter int MAX_DEFER = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ref_start,
  input  logic               ref_window,
  mem_access_if.sched        mem,
  output logic               refr,
  output refresh_pkg::bank_t refr_bank
);

  logic                active;       // refresh owed this cycle
  logic                svld;         // deferred bank served
  logic                cvld;         // pointer bank served
  logic                pvld;         // pointer blocked, bank after it served
  refresh_pkg::bank_t  pick;
  refresh_pkg::bank_t  ptr;
  refresh_pkg::bank_t  ptr_plus_1;
  refresh_pkg::bank_t  stuck_bank;
  refresh_pkg::defer_t stuck_cnt;

  assign active = ref_start || ref_window;

  assign ptr_plus_1 = (ptr == refresh_pkg::bank_t'(NUM_BANKS - 1)) ? '0 : ptr + 1'b1;

  // ####################
  // bank choice
  // ####################
  always_comb begin
    svld = 1'b0;
    cvld = 1'b0;
    pvld = 1'b0;
    if ((stuck_cnt != '0) && !(mem.acc && (mem.bank == stuck_bank))) begin
      svld = active;  // catch up on the stuck bank first
      pick = stuck_bank;
    end else if (!(mem.acc && (mem.bank == ptr))) begin
      cvld = active;
      pick = ptr;
    end else begin
      // bus owns the pointer bank, two banks minimum so the next one is free
      pvld = active;
      pick = ptr_plus_1;
    end
  end

  assign refr      = svld || cvld || pvld;
  assign refr_bank = pick;

  // ####################
  // round robin pointer
  // ####################
  always_ff @(posedge clk) begin
    if (rst)
      ptr <= '0;
    else if (cvld || pvld)
      ptr <= (pick == refresh_pkg::bank_t'(NUM_BANKS - 1)) ? '0 : pick + 1'b1;
  end

  // ####################
  // deferred bank slot
  // ####################
  always_ff @(posedge clk) begin
    if (rst) begin
      stuck_bank <= '0;
      stuck_cnt  <= '0;
    end else if (svld) begin
      stuck_cnt <= stuck_cnt - 1'b1;
    end else if (pvld) begin
      stuck_bank <= ptr;  // skipped bank is now owed a refresh
      if (stuck_cnt != refresh_pkg::defer_t'(MAX_DEFER))
        stuck_cnt <= stuck_cnt + 1'b1;
    end
  end

  a_bank_range : assert property (@(posedge clk) disable iff (rst)
    refr_bank < NUM_BANKS);

  a_no_conflict : assert property (@(posedge clk) disable iff (rst)
    (refr && mem.acc) |-> (refr_bank != mem.bank));

endmodule

// ==== design/bank_array.sv ====
module bank_array #(
  parameter int NUM_BANKS       = 7,
  parameter int RETENTION_LIMIT = 200
) (
  input  logic               clk,
  input  logic               rst,
  mem_access_if.array        mem,
  input  logic               refr,
  input  refresh_pkg::bank_t refr_bank,
  output logic               fault
);

  localparam int ROWS = 2 ** $bits(refresh_pkg::row_t);

  refresh_pkg::word_t store [NUM_BANKS][ROWS];
  logic [ROWS-1:0]    written [NUM_BANKS];  // unwritten rows read as zero
  refresh_pkg::word_t rdata_q;
  refresh_pkg::age_t  age [NUM_BANKS];
  logic               over_limit;

  // ####################
  // storage
  // ####################
  always_ff @(posedge clk) begin
    if (mem.acc) begin
      if (mem.we)
        store[mem.bank][mem.row] <= mem.wdata;
      else
        rdata_q <= written[mem.bank][mem.row] ? store[mem.bank][mem.row] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < NUM_BANKS; b++)
        written[b] <= '0;
    end else if (mem.acc && mem.we) begin
      written[mem.bank][mem.row] <= 1'b1;
    end
  end

  assign mem.rdata = rdata_q;

  // ####################
  // retention tracking
  // ####################
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < NUM_BANKS; b++)
        age[b] <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (refr && (refr_bank == refresh_pkg::bank_t'(b)))
          age[b] <= '0;
        else if (age[b] != '1)
          age[b] <= age[b] + 1'b1;  // saturates
      end
    end
  end

  always_comb begin
    over_limit = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (age[b] > refresh_pkg::age_t'(RETENTION_LIMIT))
        over_limit = 1'b1;
    end
  end

  // sticky until reset, data in that bank can no longer be trusted
  always_ff @(posedge clk) begin
    if (rst)
      fault <= 1'b0;
    else if (over_limit)
      fault <= 1'b1;
  end

  a_refr_vs_acc : assert property (@(posedge clk) disable iff (rst)
    !(refr && mem.acc && (refr_bank == mem.bank)));

endmodule

// ==== design/refresh_mem_top.sv ====
module refresh_mem_top #(
  parameter int NUM_BANKS       = 7,
  parameter int MAX_DEFER       = 2,
  parameter int REFRESH_PERIOD  = 64,
  parameter int RETENTION_LIMIT = 200
) (
  input  logic               clk,
  input  logic               rst,
  input  refresh_pkg::addr_t awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  refresh_pkg::word_t wdata,
  input  logic               wvalid,
  output logic               wready,
  output refresh_pkg::resp_t bresp,
  output logic               bvalid,
  input  logic               bready,
  input  refresh_pkg::addr_t araddr,
  input  logic               arvalid,
  output logic               arready,
  output refresh_pkg::word_t rdata,
  output refresh_pkg::resp_t rresp,
  output logic               rvalid,
  input  logic               rready,
  output logic               refr,       // refresh issued this cycle
  output refresh_pkg::bank_t refr_bank
);

  logic ref_start;
  logic ref_window;
  logic fault;

  mem_access_if mem_if ();

  axil_ctrl_fsm #(.NUM_BANKS(NUM_BANKS)) u_ctrl (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .fault,
    .mem (mem_if.ctrl)
  );

  refresh_timer #(.NUM_BANKS(NUM_BANKS), .REFRESH_PERIOD(REFRESH_PERIOD)) u_timer (
    .clk, .rst, .refr, .ref_start, .ref_window
  );

  refresh_scheduler #(.NUM_BANKS(NUM_BANKS), .MAX_DEFER(MAX_DEFER)) u_sched (
    .clk, .rst, .ref_start, .ref_window,
    .mem (mem_if.sched),
    .refr, .refr_bank
  );

  bank_array #(.NUM_BANKS(NUM_BANKS), .RETENTION_LIMIT(RETENTION_LIMIT)) u_array (
    .clk, .rst,
    .mem (mem_if.array),
    .refr, .refr_bank, .fault
  );

endmodule

// ==== sim/refresh_mem_tb.sv ====
module refresh_mem_tb;

  localparam int NUM_BANKS       = 7;
  localparam int REFRESH_PERIOD  = 64;
  localparam int RETENTION_LIMIT = 200;
  localparam int NUM_TRANS       = 400;
  localparam int MAX_CYCLES      = 6000;  // 400 transactions at up to 12 cycles, plus reset

  logic               clk = 1'b0;
  logic               rst;
  refresh_pkg::addr_t awaddr;
  logic               awvalid;
  logic               awready;
  refresh_pkg::word_t wdata;
  logic               wvalid;
  logic               wready;
  refresh_pkg::resp_t bresp;
  logic               bvalid;
  logic               bready;
  refresh_pkg::addr_t araddr;
  logic               arvalid;
  logic               arready;
  refresh_pkg::word_t rdata;
  refresh_pkg::resp_t rresp;
  logic               rvalid;
  logic               rready;
  logic               refr;
  refresh_pkg::bank_t refr_bank;

  refresh_pkg::word_t image [NUM_BANKS][16];  // expected memory contents
  logic [33:0]        rd_expect [$];          // {rresp, rdata} per read in flight
  refresh_pkg::resp_t wr_expect [$];
  int                 age [NUM_BANKS];        // cycles since each bank was refreshed
  int                 since_rst;
  logic               exp_bvalid;
  logic               exp_rvalid;
  int                 data_errs = 0;
  int                 proto_errs = 0;
  int                 refr_errs = 0;
  int                 cycles = 0;
  logic [31:0]        rng;

  refresh_mem_top DUT (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .refr, .refr_bank
  );

  always #5 clk = ~clk;

  // ####################
  // reference model
  // ####################
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic refresh_pkg::bank_t addr_bank(input refresh_pkg::addr_t a);
    return a[8:6];
  endfunction

  function automatic refresh_pkg::row_t addr_row(input refresh_pkg::addr_t a);
    return a[5:2];
  endfunction

  // status word carries the fault flag, which has to stay clear
  function automatic logic [33:0] expect_read(input refresh_pkg::addr_t a);
    if (int'(addr_bank(a)) >= NUM_BANKS)
      return {refresh_pkg::RESP_OKAY, 32'h0};
    return {refresh_pkg::RESP_OKAY, image[addr_bank(a)][addr_row(a)]};
  endfunction

  function automatic refresh_pkg::resp_t expect_write(input refresh_pkg::addr_t a);
    if (int'(addr_bank(a)) >= NUM_BANKS)
      return refresh_pkg::RESP_SLVERR;  // status is read only
    return refresh_pkg::RESP_OKAY;
  endfunction

  // ####################
  // bus drivers
  // ####################
  task automatic write_word(input refresh_pkg::addr_t a, input refresh_pkg::word_t d,
                            input int stall);
    awaddr  = a;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge clk);
    while (!(awready && wready))
      @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (stall) @(negedge clk);  // back-pressure on the response
    bready = 1'b1;
    @(posedge clk);
    while (!bvalid)
      @(posedge clk);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_word(input refresh_pkg::addr_t a, input int stall);
    araddr  = a;
    arvalid = 1'b1;
    @(posedge clk);
    while (!arready)
      @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    repeat (stall) @(negedge clk);
    rready = 1'b1;
    @(posedge clk);
    while (!rvalid)
      @(posedge clk);
    @(negedge clk);
    rready = 1'b0;
  endtask

  // ####################
  // checker
  // ####################
  always @(posedge clk) begin
    logic               wr_hs;
    logic               rd_hs;
    logic               acc_live;
    logic               exp_refr;
    refresh_pkg::bank_t acc_bank;
    refresh_pkg::resp_t exp_resp;
    logic [33:0]        exp_rd;
    wr_hs    = awvalid && awready && wvalid && wready;
    rd_hs    = arvalid && arready;
    acc_bank = wr_hs ? addr_bank(awaddr) : addr_bank(araddr);
    acc_live = (wr_hs || rd_hs) && (int'(acc_bank) < NUM_BANKS);
    if (rst) begin
      since_rst  = 0;
      exp_bvalid = 1'b0;
      exp_rvalid = 1'b0;
      foreach (age[b])
        age[b] = 0;
      foreach (image[b, r])
        image[b][r] = '0;
    end else begin
      since_rst = since_rst + 1;
      if (bvalid !== exp_bvalid || rvalid !== exp_rvalid) begin
        $display("[FAIL] t=%0t bvalid=%b rvalid=%b, expected %b %b", $time,
                 bvalid, rvalid, exp_bvalid, exp_rvalid);
        proto_errs++;
      end
      // address channels must stay closed while a response is held
      if ((awready || wready || arready) && (bvalid || rvalid)) begin
        $display("[FAIL] t=%0t address ready while a response is held", $time);
        proto_errs++;
      end
      if (awready !== wready) begin
        $display("[FAIL] t=%0t awready=%b wready=%b, expected equal", $time,
                 awready, wready);
        proto_errs++;
      end
      if (arready && (awvalid || wvalid)) begin
        $display("[FAIL] t=%0t arready high while a write is pending", $time);
        proto_errs++;
      end
      exp_bvalid = wr_hs || (bvalid && !bready);
      exp_rvalid = rd_hs || (rvalid && !rready);

      if (wr_hs) begin
        wr_expect.push_back(expect_write(awaddr));
        if (int'(addr_bank(awaddr)) < NUM_BANKS)
          image[addr_bank(awaddr)][addr_row(awaddr)] = wdata;
      end
      if (rd_hs)
        rd_expect.push_back(expect_read(araddr));

      if (bvalid && bready) begin
        if (wr_expect.size() == 0) begin
          $display("write response at t=%0t with no write outstanding", $time);
          proto_errs++;
        end else begin
          exp_resp = wr_expect.pop_front();
          if (bresp !== exp_resp) begin
            $display("[FAIL] t=%0t bresp=%0d, expected %0d", $time, bresp, exp_resp);
            data_errs++;
          end
        end
      end
      if (rvalid && rready) begin
        if (rd_expect.size() == 0) begin
          $display("read response at t=%0t with no read outstanding", $time);
          proto_errs++;
        end else begin
          exp_rd = rd_expect.pop_front();
          if ({rresp, rdata} !== exp_rd) begin
            $display("[FAIL] t=%0t read gave resp=%0d data=%h, expected resp=%0d data=%h",
                     $time, rresp, rdata, exp_rd[33:32], exp_rd[31:0]);
            data_errs++;
          end
        end
      end

      // burst of NUM_BANKS cycles at every period boundary
      exp_refr = (since_rst >= REFRESH_PERIOD) && ((since_rst % REFRESH_PERIOD) < NUM_BANKS);
      if (refr !== exp_refr) begin
        $display("[FAIL] t=%0t refr=%b, expected %b", $time, refr, exp_refr);
        refr_errs++;
      end
      if (int'(refr_bank) >= NUM_BANKS) begin
        $display("[FAIL] t=%0t refr_bank=%0d out of range", $time, refr_bank);
        refr_errs++;
      end
      if (refr && acc_live && refr_bank == acc_bank) begin
        $display("[FAIL] t=%0t refresh hit bank %0d during an access", $time, acc_bank);
        refr_errs++;
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (refr && int'(refr_bank) == b) begin
          age[b] = 0;
        end else begin
          age[b] = age[b] + 1;
          if (age[b] == RETENTION_LIMIT) begin
            $display("[FAIL] t=%0t bank %0d not refreshed for %0d cycles", $time, b,
                     RETENTION_LIMIT);
            refr_errs++;
          end
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ####################
  // stimulus
  // ####################
  initial begin
    refresh_pkg::bank_t bank;
    refresh_pkg::row_t  row;
    refresh_pkg::addr_t addr;
    logic               is_wr;
    logic               gap;
    int                 stall;
    int                 leftover;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    rng     = 32'd77;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int n = 0; n < NUM_TRANS; n++) begin
      rng   = xorshift32(rng);
      bank  = rng[2:0];  // code 7 is the status address
      row   = rng[6:3];
      stall = int'(rng[9:8]);
      is_wr = rng[10];
      gap   = (rng[12:11] == 2'b00);
      addr  = {23'h0, bank, row, 2'b00};
      rng   = xorshift32(rng);
      if (is_wr)
        write_word(addr, rng, stall);
      else
        read_word(addr, stall);
      if (gap)
        @(negedge clk);
    end
    repeat (4) @(negedge clk);
    leftover = rd_expect.size() + wr_expect.size();
    if (leftover != 0)
      $display("%0d responses never arrived", leftover);
    $display("done: %0d transactions, %0d data errors, %0d protocol errors, %0d refresh errors",
             NUM_TRANS, data_errs, proto_errs + leftover, refr_errs);
    if (data_errs + proto_errs + refr_errs + leftover == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
design/refresh_pkg.sv
design/mem_access_if.sv
design/axil_ctrl_fsm.sv
design/refresh_timer.sv
design/refresh_scheduler.sv
design/bank_array.sv
design/refresh_mem_top.sv
sim/refresh_mem_tb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f list.f --top-module refresh_mem_tb \
		-o refresh_mem_sim
	@out="$$(./obj_dir/refresh_mem_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing -f list.f --top-module refresh_mem_tb

clean:
	rm -rf obj_dir
